// File: include/filter_taps.svh
`ifndef filter_taps_svh
`define filter_taps_svh

// coefficients of the first convolution layer, tap 0 first
localparam sample_t filter_taps [n_taps] = '{
	-16'sd159,
	-16'sd86,
	16'sd62,
	-16'sd61,
	16'sd17,
	16'sd116,
	-16'sd14,
	-16'sd180,
	-16'sd98,
	16'sd37,
	16'sd241,
	-16'sd173,
	-16'sd228,
	-16'sd175,
	-16'sd142,
	16'sd196,
	16'sd98,
	-16'sd68,
	-16'sd69,
	-16'sd40,
	-16'sd184,
	-16'sd146,
	-16'sd247,
	-16'sd171,
	16'sd245,
	16'sd167,
	-16'sd49,
	-16'sd82,
	16'sd26,
	16'sd102,
	-16'sd84,
	16'sd123,
	-16'sd240
};

`endif

// File: logic/conv_pkg.sv
package conv_pkg;

	localparam int sample_w = 16;
	localparam int n_samples = 64;
	localparam int n_taps = 33;
	localparam int n_outputs = n_samples - n_taps + 1;
	localparam int n_lanes = 4;
	localparam int n_groups = n_outputs / n_lanes;
	localparam int sat_max = 32767;
	localparam int sat_min = -32768;
	localparam int wide_w = 2 * sample_w + 8; // product plus headroom for one add

	typedef logic signed [sample_w-1:0] sample_t;
	typedef logic signed [wide_w-1:0] wide_t;
	typedef logic [5:0] sample_addr_t;
	typedef logic [5:0] tap_index_t;
	typedef logic [4:0] out_index_t;

	`include "filter_taps.svh"

	function automatic sample_t tap_value(input tap_index_t k);
		if (k < tap_index_t'(n_taps))
			return filter_taps[k];
		else
			return '0; // past the end of the filter
	endfunction

	function automatic sample_t saturate(input wide_t v);
		if (v > sat_max)
			return sample_t'(sat_max);
		else if (v < sat_min)
			return sample_t'(sat_min);
		else
			return sample_t'(v);
	endfunction

endpackage

// File: logic/sample_loader.sv
`timescale 1ns/1ns

module sample_loader import conv_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  sample_t s_data,
	input  logic    s_valid,
	output logic    s_ready,
	input  logic    frame_drained,
	output logic    step_valid,
	output logic    first_step,
	output logic    last_step,
	output sample_t lane_sample [n_lanes],
	output sample_t tap
);

	typedef enum logic [1:0] {
		st_fill,
		st_compute,
		st_drain
	} frame_state_t;

	frame_state_t state;
	sample_addr_t wr_addr;
	logic [$clog2(n_groups)-1:0] group;
	tap_index_t k;
	logic [1:0] bubble; // idle cycles left before the next group
	logic wr_en;
	logic issue;
	sample_addr_t rd_addr [n_lanes];

	// one copy of the frame per lane so all four lanes read in one cycle
	sample_t bank [n_lanes][n_samples];

	assign wr_en = s_valid && s_ready;
	assign issue = (state == st_compute) && (bubble == 2'd0);

	always_comb begin
		for (int l = 0; l < n_lanes; l++)
			rd_addr[l] = sample_addr_t'(n_lanes * group + l + k); // x[4g + lane + k]
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_fill;
			s_ready <= 1'b1;
			wr_addr <= '0;
			group <= '0;
			k <= '0;
			bubble <= '0;
			step_valid <= 1'b0;
		end else begin
			step_valid <= issue;
			case (state)
				st_fill: begin
					if (wr_en) begin
						wr_addr <= wr_addr + 1'b1; // wraps to 0 after the last sample
						if (wr_addr == sample_addr_t'(n_samples - 1)) begin
							state <= st_compute;
							s_ready <= 1'b0;
							group <= '0;
							k <= '0;
							bubble <= '0;
						end
					end
				end
				st_compute: begin
					if (bubble != 2'd0) begin
						bubble <= bubble - 1'b1;
					end else if (k == tap_index_t'(n_taps - 1)) begin
						k <= '0;
						bubble <= 2'd2; // gap between groups
						group <= group + 1'b1;
						if (group == n_groups - 1)
							state <= st_drain;
					end else begin
						k <= k + 1'b1;
					end
				end
				st_drain: begin
					if (frame_drained) begin
						state <= st_fill;
						s_ready <= 1'b1;
					end
				end
				default: state <= st_fill;
			endcase
		end
	end

	// store write and registered reads, tap and flags aligned to the read
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int l = 0; l < n_lanes; l++)
				bank[l][wr_addr] <= s_data;
		end
		for (int l = 0; l < n_lanes; l++)
			lane_sample[l] <= bank[l][rd_addr[l]];
		tap <= tap_value(k);
		first_step <= (k == '0);
		last_step <= (k == tap_index_t'(n_taps - 1));
	end

endmodule

// File: logic/mac_lanes.sv
`timescale 1ns/1ns

module mac_lanes import conv_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    step_valid,
	input  logic    first_step,
	input  logic    last_step,
	input  sample_t lane_sample [n_lanes],
	input  sample_t tap,
	output logic    lanes_done,
	output sample_t lane_sum [n_lanes]
);

	sample_t product [n_lanes]; // saturated product, stage one
	logic prod_valid;
	logic prod_first;
	logic prod_last;

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			lanes_done <= 1'b0;
		end else begin
			prod_valid <= step_valid;
			lanes_done <= prod_valid && prod_last; // sums are final next cycle
		end
	end

	always_ff @(posedge clk) begin
		prod_first <= first_step;
		prod_last <= last_step;
		for (int l = 0; l < n_lanes; l++) begin
			product[l] <= saturate(wide_t'(lane_sample[l]) * wide_t'(tap));
			if (prod_valid) begin
				if (prod_first)
					lane_sum[l] <= product[l]; // same as sat(0 + product)
				else
					lane_sum[l] <= saturate(wide_t'(lane_sum[l]) + wide_t'(product[l]));
			end
		end
	end

endmodule

// File: logic/result_streamer.sv
`timescale 1ns/1ns

module result_streamer import conv_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    lanes_done,
	input  sample_t lane_sum [n_lanes],
	output sample_t m_data,
	output logic    m_valid,
	input  logic    m_ready,
	output logic    frame_drained
);

	logic [$clog2(n_groups)-1:0] wr_group;
	logic pending; // frame complete, first output not loaded yet
	out_index_t rd_index;
	out_index_t rd_sel;
	logic xfer;
	sample_t rectified [n_lanes];

	// output j lives in bank j mod 4 at entry j div 4
	sample_t bank [n_lanes][n_groups];

	assign xfer = m_valid && m_ready;
	assign rd_sel = pending ? out_index_t'(0) : rd_index + 1'b1;

	always_comb begin
		for (int l = 0; l < n_lanes; l++)
			rectified[l] = (lane_sum[l] < 0) ? sample_t'(0) : lane_sum[l];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_group <= '0;
			pending <= 1'b0;
			m_valid <= 1'b0;
			rd_index <= '0;
			frame_drained <= 1'b0;
		end else begin
			frame_drained <= 1'b0;
			if (lanes_done) begin
				wr_group <= wr_group + 1'b1;
				if (wr_group == n_groups - 1)
					pending <= 1'b1;
			end
			if (pending) begin
				pending <= 1'b0;
				m_valid <= 1'b1;
				rd_index <= '0;
			end else if (xfer) begin
				rd_index <= rd_index + 1'b1; // back to 0 after the last output
				if (rd_index == out_index_t'(n_outputs - 1)) begin
					m_valid <= 1'b0;
					frame_drained <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lanes_done) begin
			for (int l = 0; l < n_lanes; l++)
				bank[l][wr_group] <= rectified[l];
		end
		if (pending || xfer)
			m_data <= bank[rd_sel[1:0]][rd_sel[4:2]]; // held until the transfer
	end

endmodule

// File: logic/conv_layer.sv
`timescale 1ns/1ns

module conv_layer import conv_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  sample_t s_data,
	input  logic    s_valid,
	output logic    s_ready,
	output sample_t m_data,
	output logic    m_valid,
	input  logic    m_ready
);

	logic step_valid;
	logic first_step;
	logic last_step;
	sample_t lane_sample [n_lanes];
	sample_t tap;
	logic lanes_done;
	sample_t lane_sum [n_lanes];
	logic frame_drained;

	sample_loader u_decode (
		.clk           (clk),
		.reset         (reset),
		.s_data        (s_data),
		.s_valid       (s_valid),
		.s_ready       (s_ready),
		.frame_drained (frame_drained),
		.step_valid    (step_valid),
		.first_step    (first_step),
		.last_step     (last_step),
		.lane_sample   (lane_sample),
		.tap           (tap)
	);

	mac_lanes u_execute (
		.clk         (clk),
		.reset       (reset),
		.step_valid  (step_valid),
		.first_step  (first_step),
		.last_step   (last_step),
		.lane_sample (lane_sample),
		.tap         (tap),
		.lanes_done  (lanes_done),
		.lane_sum    (lane_sum)
	);

	result_streamer u_result (
		.clk           (clk),
		.reset         (reset),
		.lanes_done    (lanes_done),
		.lane_sum      (lane_sum),
		.m_data        (m_data),
		.m_valid       (m_valid),
		.m_ready       (m_ready),
		.frame_drained (frame_drained)
	);

endmodule

// File: test/conv_layer_assertions.sv
`timescale 1ns/1ns

module conv_layer_assertions import conv_pkg::*; (
	input logic    clk,
	input logic    reset,
	input logic    s_ready,
	input sample_t m_data,
	input logic    m_valid,
	input logic    m_ready
);

	// an offered result stays put until the sink takes it
	hold_until_ready: assert property (@(posedge clk) disable iff (reset)
		m_valid && !m_ready |=> m_valid && $stable(m_data))
		else $error("m_valid or m_data changed before m_ready");

	input_output_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(s_ready && m_valid))
		else $error("s_ready and m_valid high in the same cycle");

	idle_after_reset: assert property (@(posedge clk)
		reset |=> !m_valid)
		else $error("m_valid high in the cycle after reset");

endmodule

bind conv_layer conv_layer_assertions u_assertions (
	.clk     (clk),
	.reset   (reset),
	.s_ready (s_ready),
	.m_data  (m_data),
	.m_valid (m_valid),
	.m_ready (m_ready)
);

// File: test/conv_layer_tb.sv
`timescale 1ns/1ns

module conv_layer_tb import conv_pkg::*; ();

	localparam int frame_cycles = n_samples + n_groups * 40 + n_outputs * 8;
	localparam int total_frames = 7; // frames over all five tests
	localparam int watchdog_ns = total_frames * frame_cycles * 8 * 4 + 16 * 8;
	localparam int frame_random = 0;
	localparam int frame_max = 1;
	localparam int frame_negative = 2;

	logic clk = 1'b0;
	logic reset;
	sample_t s_data;
	logic s_valid;
	logic s_ready;
	sample_t m_data;
	logic m_valid;
	logic m_ready;

	logic [31:0] lfsr;
	sample_t in_q [$];
	sample_t exp_q [$]; // expected results in arrival order
	int errors = 0;
	int checked = 0;
	int out_count = 0;
	int tests_bad = 0;

	conv_layer DUT (
		.clk     (clk),
		.reset   (reset),
		.s_data  (s_data),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.m_data  (m_data),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// output j is the saturating sum over the 33 taps with negatives clamped to zero
	function automatic sample_t reference_output(input sample_t x [n_samples], input int j);
		sample_t acc;
		sample_t prod;
		acc = '0;
		for (int k = 0; k < n_taps; k++) begin
			prod = saturate(wide_t'(x[j + k]) * wide_t'(tap_value(tap_index_t'(k))));
			acc = saturate(wide_t'(acc) + wide_t'(prod));
		end
		return (acc < 0) ? sample_t'(0) : acc;
	endfunction

	task automatic check_value(input sample_t got, input sample_t exp, input string what);
		checked++;
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic load_frame(input int kind);
		sample_t x [n_samples];
		logic [31:0] r;
		for (int i = 0; i < n_samples; i++) begin
			case (kind)
				frame_max: x[i] = sample_t'(sat_max);
				frame_negative: begin
					take_bits(15, r);
					x[i] = sample_t'({1'b1, r[14:0]});
				end
				default: begin
					take_bits(16, r);
					x[i] = sample_t'(r[15:0]);
				end
			endcase
			in_q.push_back(x[i]);
		end
		for (int j = 0; j < n_outputs; j++)
			exp_q.push_back(reference_output(x, j));
	endtask

	// feeds in_q and drains the results until every expected output has left
	task automatic stream(input int n_frames, input bit gaps);
		int sent;
		int seen;
		int cycles;
		int total_in;
		int total_out;
		logic xfer_in;
		logic [31:0] r;
		sent = 0;
		seen = 0;
		cycles = 0;
		total_in = n_frames * n_samples;
		total_out = n_frames * n_outputs;
		while (seen < total_out && cycles < n_frames * frame_cycles * 3) begin
			@(posedge clk);
			cycles++;
			if (sent / n_samples > seen / n_outputs && s_ready) begin
				$display("s_ready high at %0t ns while a frame is still streaming out", $time);
				errors++;
			end
			xfer_in = s_valid && s_ready;
			if (xfer_in)
				sent++;
			if (m_valid && m_ready)
				seen++;
			if (sent >= total_in) begin
				s_valid <= 1'b0;
			end else if (!(s_valid && !xfer_in)) begin
				if (gaps) begin
					take_bits(2, r);
					s_valid <= (r[1:0] != 2'b00);
				end else begin
					s_valid <= 1'b1;
				end
				s_data <= in_q[sent];
			end
			if (gaps) begin
				take_bits(1, r);
				m_ready <= r[0];
			end else begin
				m_ready <= 1'b1;
			end
		end
		if (seen < total_out) begin
			$display("frame %0d ended with only %0d of %0d outputs",
				seen / n_outputs + 1, seen % n_outputs, n_outputs);
			errors++;
		end
		m_ready <= 1'b1; // let any stray extra output show up at the collector
		@(negedge clk);
		exp_q.delete();
		in_q.delete();
	endtask

	task automatic run_test(input int id, input string name, input int kind,
		input int n_frames, input bit gaps);
		int errors_before;
		errors_before = errors;
		for (int f = 0; f < n_frames; f++)
			load_frame(kind);
		stream(n_frames, gaps);
		if (errors == errors_before) begin
			$display("test %0d %s: ok", id, name);
		end else begin
			$display("test %0d %s: %0d errors", id, name, errors - errors_before);
			tests_bad++;
		end
	endtask

	always @(posedge clk) begin
		if (!reset && m_valid && m_ready) begin
			if (exp_q.size() == 0) begin
				$display("output of %0d at %0t ns arrived with no result expected", m_data, $time);
				errors++;
			end else begin
				check_value(m_data, exp_q.pop_front(), $sformatf("output %0d", out_count % n_outputs));
			end
			out_count++;
		end
	end

	initial begin
		#(watchdog_ns);
		$display("run did not finish within %0d ns", watchdog_ns);
		$display("tests failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		s_data = '0;
		s_valid = 1'b0;
		m_ready = 1'b1;
		lfsr = 32'hcb8e_dd52;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		run_test(1, "random frame", frame_random, 1, 1'b0);
		run_test(2, "full scale frame", frame_max, 1, 1'b0);
		run_test(3, "negative frame", frame_negative, 1, 1'b0);
		run_test(4, "random frame with gaps", frame_random, 1, 1'b1);
		run_test(5, "three back-to-back frames", frame_random, 3, 1'b0);
		repeat (4) @(posedge clk);
		$display("5 tests run, %0d with errors, %0d outputs checked, %0d errors",
			tests_bad, checked, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+include
logic/conv_pkg.sv
logic/sample_loader.sv
logic/mac_lanes.sv
logic/result_streamer.sv
logic/conv_layer.sv
test/conv_layer_assertions.sv
test/conv_layer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the convolution layer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module conv_layer_tb -Mdir obj_dir -f compile.f \
	|| { echo "verilator build did not complete"; exit 1; }

out="$(./obj_dir/Vconv_layer_tb 2>&1)"
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || exit 1
